/* source/queue_types_pkg.sv */
// Queue entry struct, entry width and consumer credit counter type

package queue_types_pkg;

    // ------------------------------------------------------------------------
    // Datapath word
    // ------------------------------------------------------------------------

    // One queue word as the producer hands it over
    // Field order puts the framing bits in the top of the stored word
    typedef struct packed {
        logic         sop;
        logic         eop;
        logic [6:0]   qid;
        logic [187:0] payload;
    } queue_entry_t;

    // One register file word is 197 bits wide
    localparam int ENTRY_W = $bits(queue_entry_t);

    // ------------------------------------------------------------------------
    // Flow control
    // ------------------------------------------------------------------------

    // Consumer credits may run ahead of the queue depth, so the counter is
    // wider than a pointer
    localparam int CREDIT_W = 8;

    typedef logic [CREDIT_W-1:0] credit_cnt_t;

endpackage

/* source/pwr_types_pkg.sv */
// Power-gate sequencer state enum and power control struct

package pwr_types_pkg;

    // Sequencer states, walked in this order through a sleep and wake cycle
    typedef enum logic [2:0] {
        AWAKE    = 3'd0,
        ISOLATE  = 3'd1,
        OFF      = 3'd2,
        POWER_UP = 3'd3,
        RELEASE  = 3'd4
    } pwr_state_e;

    // Control pair from the sequencer to the register file
    // isol_en clamps the read data, pwr_enable_b high removes array power
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } pwr_ctrl_t;

endpackage

/* source/reset_sync_scan.sv */
// Two-flop reset synchronizer with scan reset bypass

`timescale 1ns/1ps

module reset_sync_scan (
     input  logic clk
    ,input  logic arst_n
    ,input  logic scan_rstbypen
    ,input  logic scan_byprst_b
    ,output logic rst_n_sync
);

    // Two stages of flops; the second one feeds the domain
    logic [1:0] sync_q;

    // Assertion is immediate, release walks a one through both flops
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // In scan mode the tester owns the reset directly
    assign rst_n_sync = scan_rstbypen ? scan_byprst_b : sync_q[1];

endmodule

/* source/rf_pg_dual_clk.sv */
// Behavioral power-gated two-port register file with isolation and power-enable acknowledge

`timescale 1ns/1ps

module rf_pg_dual_clk #(
     parameter int DEPTH       = 8
    ,parameter int ADDR_W      = 3
    ,parameter int PWR_ACK_DLY = 4
) (
     input  logic                         wclk
    ,input  logic                         rclk
    ,input  logic                         rst_n_sync

    ,input  logic                         we
    ,input  logic [ADDR_W-1:0]            waddr
    ,input  queue_types_pkg::queue_entry_t wdata

    ,input  logic                         re
    ,input  logic [ADDR_W-1:0]            raddr
    ,output queue_types_pkg::queue_entry_t rdata

    ,input  pwr_types_pkg::pwr_ctrl_t     pwr_ctrl
    ,output logic                         pwr_enable_b_out
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    logic [queue_types_pkg::ENTRY_W-1:0] mem [DEPTH];
    logic [queue_types_pkg::ENTRY_W-1:0] rdata_q;

    // Acknowledge delay line for the power-enable chain
    logic [PWR_ACK_DLY-1:0] ack_sr_q;

    // Write port on wclk
    // With power removed the cells lose their state and the model clears them to zero
    always_ff @(posedge wclk) begin
        if (pwr_ctrl.pwr_enable_b) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // The read port on rclk is registered like the macro output latch
    always_ff @(posedge rclk) begin
        if (re) begin
            rdata_q <= mem[raddr];
        end
    end

    // The isolation clamp forces the outputs low while the array is unsafe
    assign rdata = pwr_ctrl.isol_en ? '0 : queue_types_pkg::queue_entry_t'(rdata_q);

    // ------------------------------------------------------------------------
    // Power-enable chain
    // ------------------------------------------------------------------------

    // The enable ripples through the array's power switches
    // The acknowledge comes out PWR_ACK_DLY wclk cycles after the request
    always_ff @(posedge wclk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            ack_sr_q <= '0;
        end else begin
            ack_sr_q <= {ack_sr_q[PWR_ACK_DLY-2:0], pwr_ctrl.pwr_enable_b};
        end
    end

    assign pwr_enable_b_out = ack_sr_q[PWR_ACK_DLY-1];

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // The write controller must stay idle for the whole isolated window
    a_no_write_isolated : assert property (
        @(posedge wclk) disable iff (!rst_n_sync)
        pwr_ctrl.isol_en |-> !we
    );

    // The read side lives in the other domain and must also be quiet
    a_no_read_isolated : assert property (
        @(posedge rclk) disable iff (!rst_n_sync)
        pwr_ctrl.isol_en |-> !re
    );

endmodule

/* source/pwr_gate_seq.sv */
// Power-gate sequencer for the register file, sleeping only on an empty queue

`timescale 1ns/1ps

module pwr_gate_seq (
     input  logic                     wclk
    ,input  logic                     rst_n_sync
    ,input  logic                     sleep_req
    ,input  logic                     queue_empty
    ,input  logic                     pwr_ack
    ,output pwr_types_pkg::pwr_ctrl_t pwr_ctrl
    ,output logic                     pwr_awake
);

    pwr_types_pkg::pwr_state_e state_q;
    pwr_types_pkg::pwr_state_e state_d;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            // Sleep waits until the last entry has been read out
            pwr_types_pkg::AWAKE: begin
                if (sleep_req && queue_empty) begin
                    state_d = pwr_types_pkg::ISOLATE;
                end
            end
            // One cycle of clamp before the supply goes away
            pwr_types_pkg::ISOLATE: begin
                state_d = pwr_types_pkg::OFF;
            end
            // Wake only once the power-off has been acknowledged, so the
            // later falling acknowledge really belongs to the power-up
            pwr_types_pkg::OFF: begin
                if (!sleep_req && pwr_ack) begin
                    state_d = pwr_types_pkg::POWER_UP;
                end
            end
            pwr_types_pkg::POWER_UP: begin
                if (!pwr_ack) begin
                    state_d = pwr_types_pkg::RELEASE;
                end
            end
            pwr_types_pkg::RELEASE: begin
                state_d = pwr_types_pkg::AWAKE;
            end
            default: begin
                state_d = pwr_types_pkg::AWAKE;
            end
        endcase
    end

    always_ff @(posedge wclk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            state_q <= pwr_types_pkg::AWAKE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs decoded from the state register
    // ------------------------------------------------------------------------

    // Isolation covers the whole window the array is not fully powered
    assign pwr_ctrl.isol_en = (state_q == pwr_types_pkg::ISOLATE) ||
                              (state_q == pwr_types_pkg::OFF) ||
                              (state_q == pwr_types_pkg::POWER_UP);

    assign pwr_ctrl.pwr_enable_b = (state_q == pwr_types_pkg::OFF);

    // Producer may push only here
    assign pwr_awake = (state_q == pwr_types_pkg::AWAKE);

    // An entry held in the array during isolation would be lost at power-off
    a_isolate_only_empty : assert property (
        @(posedge wclk) disable iff (!rst_n_sync)
        (state_q == pwr_types_pkg::ISOLATE) |-> queue_empty
    );

endmodule

/* source/queue_wr_ctrl.sv */
// Write pointer, read pointer crossing, empty detection and producer credit return

`timescale 1ns/1ps

module queue_wr_ctrl #(
     parameter int ADDR_W = 3
) (
     input  logic                          wclk
    ,input  logic                          rst_n_sync

    ,input  logic                          in_push
    ,input  queue_types_pkg::queue_entry_t in_entry
    ,output logic                          in_credit

    ,output logic                          we
    ,output logic [ADDR_W-1:0]             waddr
    ,output queue_types_pkg::queue_entry_t wdata

    ,input  logic [ADDR_W:0]               rd_ptr_gray
    ,output logic [ADDR_W:0]               wr_ptr_gray
    ,output logic                          queue_empty
);

    // Pointers carry one wrap bit above the address
    logic [ADDR_W:0] wr_bin_q;
    logic [ADDR_W:0] wr_bin_nxt;
    logic [ADDR_W:0] rd_sync1_q;
    logic [ADDR_W:0] rd_sync2_q;
    // Read position up to which credits have gone back to the producer
    logic [ADDR_W:0] cred_bin_q;
    logic [ADDR_W:0] cred_gray;
    logic            full;

    assign wr_bin_nxt = wr_bin_q + 1'b1;
    assign cred_gray  = cred_bin_q ^ (cred_bin_q >> 1);

    always_ff @(posedge wclk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            wr_bin_q    <= '0;
            wr_ptr_gray <= '0;
            rd_sync1_q  <= '0;
            rd_sync2_q  <= '0;
            cred_bin_q  <= '0;
            in_credit   <= 1'b0;
        end else begin
            // Pushes go straight to the array and the pointer follows at the same edge
            if (in_push) begin
                wr_bin_q    <= wr_bin_nxt;
                wr_ptr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            end
            // Gray code keeps the crossing to a single changing bit
            rd_sync1_q <= rd_ptr_gray;
            rd_sync2_q <= rd_sync1_q;
            // Return one credit per cycle until caught up with the reader
            in_credit <= (cred_gray != rd_sync2_q);
            if (cred_gray != rd_sync2_q) begin
                cred_bin_q <= cred_bin_q + 1'b1;
            end
        end
    end

    assign we    = in_push;
    assign waddr = wr_bin_q[ADDR_W-1:0];
    assign wdata = in_entry;

    // In Gray code the queue is full when the top two bits differ and the rest is equal
    assign full = ((wr_ptr_gray ^ rd_sync2_q) == {2'b11, {(ADDR_W-1){1'b0}}});

    // A push in flight counts as occupancy so sleep cannot race it
    assign queue_empty = (wr_ptr_gray == rd_sync2_q) && !in_push;

    // Producer credits must prevent any overflow of the array
    a_no_push_full : assert property (
        @(posedge wclk) disable iff (!rst_n_sync)
        in_push |-> !full
    );

endmodule

/* source/queue_rd_ctrl.sv */
// Read pointer, write pointer crossing, consumer credit count and output valid

`timescale 1ns/1ps

module queue_rd_ctrl #(
     parameter int ADDR_W = 3
) (
     input  logic                          rclk
    ,input  logic                          rst_n_sync

    ,input  logic                          out_credit

    ,output logic                          re
    ,output logic [ADDR_W-1:0]             raddr
    ,input  queue_types_pkg::queue_entry_t rdata

    ,output logic                          out_valid
    ,output queue_types_pkg::queue_entry_t out_entry

    ,input  logic [ADDR_W:0]               wr_ptr_gray
    ,output logic [ADDR_W:0]               rd_ptr_gray
);

    logic [ADDR_W:0]              rd_bin_q;
    logic [ADDR_W:0]              rd_bin_nxt;
    logic [ADDR_W:0]              wr_sync1_q;
    logic [ADDR_W:0]              wr_sync2_q;
    queue_types_pkg::credit_cnt_t credit_q;

    assign rd_bin_nxt = rd_bin_q + 1'b1;

    // Read only with data visible here and a credit from the consumer
    assign re    = (rd_ptr_gray != wr_sync2_q) && (credit_q != '0);
    assign raddr = rd_bin_q[ADDR_W-1:0];

    always_ff @(posedge rclk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            rd_bin_q    <= '0;
            rd_ptr_gray <= '0;
            wr_sync1_q  <= '0;
            wr_sync2_q  <= '0;
            credit_q    <= '0;
            out_valid   <= 1'b0;
        end else begin
            if (re) begin
                rd_bin_q    <= rd_bin_nxt;
                rd_ptr_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            end
            // Write pointer arrives from wclk through two flops
            wr_sync1_q <= wr_ptr_gray;
            wr_sync2_q <= wr_sync1_q;
            // A grant and a read in the same cycle cancel out
            case ({out_credit, re})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
            // Valid lines up with the registered read data
            out_valid <= re;
        end
    end

    // Data is meaningful only together with out_valid
    assign out_entry = rdata;

endmodule

/* source/dual_clk_queue.sv */
// Top level of the dual-clock credit queue on a power-gated register file

`timescale 1ns/1ps

module dual_clk_queue #(
     parameter int DEPTH       = 8
    ,parameter int ADDR_W      = $clog2(DEPTH)
    ,parameter int PWR_ACK_DLY = 4
) (
     input  logic                          wclk
    ,input  logic                          rclk
    ,input  logic                          arst_n
    ,input  logic                          scan_rstbypen
    ,input  logic                          scan_byprst_b

    // Producer side, wclk
    ,input  logic                          in_push
    ,input  queue_types_pkg::queue_entry_t in_entry
    ,output logic                          in_credit

    // Consumer side, rclk
    ,input  logic                          out_credit
    ,output logic                          out_valid
    ,output queue_types_pkg::queue_entry_t out_entry

    // Power control, wclk
    ,input  logic                          sleep_req
    ,output logic                          pwr_awake
);

    logic                          wrst_n;
    logic                          rrst_n;

    logic                          we;
    logic [ADDR_W-1:0]             waddr;
    queue_types_pkg::queue_entry_t wdata;
    logic                          re;
    logic [ADDR_W-1:0]             raddr;
    queue_types_pkg::queue_entry_t rdata;

    logic [ADDR_W:0]               wr_ptr_gray;
    logic [ADDR_W:0]               rd_ptr_gray;
    logic                          queue_empty;
    pwr_types_pkg::pwr_ctrl_t      pwr_ctrl;
    logic                          pwr_ack;

    // ------------------------------------------------------------------------
    // Reset per clock domain
    // ------------------------------------------------------------------------

    reset_sync_scan i_wrst_sync (
         .clk           (wclk)
        ,.arst_n        (arst_n)
        ,.scan_rstbypen (scan_rstbypen)
        ,.scan_byprst_b (scan_byprst_b)
        ,.rst_n_sync    (wrst_n)
    );

    reset_sync_scan i_rrst_sync (
         .clk           (rclk)
        ,.arst_n        (arst_n)
        ,.scan_rstbypen (scan_rstbypen)
        ,.scan_byprst_b (scan_byprst_b)
        ,.rst_n_sync    (rrst_n)
    );

    // ------------------------------------------------------------------------
    // Controllers, sequencer and storage
    // ------------------------------------------------------------------------

    queue_wr_ctrl #(.ADDR_W(ADDR_W)) i_wr_ctrl (
         .wclk        (wclk)
        ,.rst_n_sync  (wrst_n)
        ,.in_push     (in_push)
        ,.in_entry    (in_entry)
        ,.in_credit   (in_credit)
        ,.we          (we)
        ,.waddr       (waddr)
        ,.wdata       (wdata)
        ,.rd_ptr_gray (rd_ptr_gray)
        ,.wr_ptr_gray (wr_ptr_gray)
        ,.queue_empty (queue_empty)
    );

    queue_rd_ctrl #(.ADDR_W(ADDR_W)) i_rd_ctrl (
         .rclk        (rclk)
        ,.rst_n_sync  (rrst_n)
        ,.out_credit  (out_credit)
        ,.re          (re)
        ,.raddr       (raddr)
        ,.rdata       (rdata)
        ,.out_valid   (out_valid)
        ,.out_entry   (out_entry)
        ,.wr_ptr_gray (wr_ptr_gray)
        ,.rd_ptr_gray (rd_ptr_gray)
    );

    pwr_gate_seq i_pwr_seq (
         .wclk        (wclk)
        ,.rst_n_sync  (wrst_n)
        ,.sleep_req   (sleep_req)
        ,.queue_empty (queue_empty)
        ,.pwr_ack     (pwr_ack)
        ,.pwr_ctrl    (pwr_ctrl)
        ,.pwr_awake   (pwr_awake)
    );

    // The power-enable chain and the IP reset belong to the write domain
    rf_pg_dual_clk #(
         .DEPTH       (DEPTH)
        ,.ADDR_W      (ADDR_W)
        ,.PWR_ACK_DLY (PWR_ACK_DLY)
    ) i_rf (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.rst_n_sync       (wrst_n)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pwr_ctrl         (pwr_ctrl)
        ,.pwr_enable_b_out (pwr_ack)
    );

    // The producer has to honour pwr_awake as well as its credits
    a_no_push_asleep : assert property (
        @(posedge wclk) disable iff (!wrst_n)
        in_push |-> pwr_awake
    );

endmodule

/* bench/tb_dual_clk_queue.sv */
// Testbench for the dual-clock credit queue driven by commands from the input data file

`timescale 1ns/1ps

module tb_dual_clk_queue;

    localparam int DEPTH      = 8;
    localparam int WAIT_LIMIT = 200;

    logic                          wclk;
    logic                          rclk;
    logic                          arst_n;
    logic                          scan_rstbypen;
    logic                          scan_byprst_b;
    logic                          in_push;
    queue_types_pkg::queue_entry_t in_entry;
    logic                          in_credit;
    logic                          out_credit;
    logic                          out_valid;
    queue_types_pkg::queue_entry_t out_entry;
    logic                          sleep_req;
    logic                          pwr_awake;

    // Scoreboard of pushed entries with the oldest first
    queue_types_pkg::queue_entry_t sb_q[$];
    int prod_credits;
    int out_count;
    int credit_count;

    dual_clk_queue #(
         .DEPTH       (DEPTH)
        ,.PWR_ACK_DLY (4)
    ) dut_i (
         .wclk          (wclk)
        ,.rclk          (rclk)
        ,.arst_n        (arst_n)
        ,.scan_rstbypen (scan_rstbypen)
        ,.scan_byprst_b (scan_byprst_b)
        ,.in_push       (in_push)
        ,.in_entry      (in_entry)
        ,.in_credit     (in_credit)
        ,.out_credit    (out_credit)
        ,.out_valid     (out_valid)
        ,.out_entry     (out_entry)
        ,.sleep_req     (sleep_req)
        ,.pwr_awake     (pwr_awake)
    );

    initial wclk = 1'b0;
    always #50 wclk = ~wclk;

    // Read clock has the same period and is shifted by 37 ns
    initial rclk = 1'b0;
    always begin
        #37;
        forever begin
            #50 rclk = ~rclk;
        end
    end

    // ------------------------------------------------------------------------
    // Error reporting
    // ------------------------------------------------------------------------

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] actual,
                               input logic [255:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                      $time, name, actual, expected));
        end
    endtask

    // ------------------------------------------------------------------------
    // Monitors sample in the middle of each clock period
    // ------------------------------------------------------------------------

    // Each out_valid must carry the oldest entry not yet read
    always @(negedge rclk) begin
        if (arst_n && out_valid) begin
            if (sb_q.size() == 0) begin
                stop_with_error("out_valid pulsed while no entry was pending");
            end else begin
                check_value("out_entry", out_entry, sb_q.pop_front());
            end
            out_count++;
        end
    end

    // Producer credit count and the power state seen from the write side
    always @(negedge wclk) begin
        if (arst_n) begin
            if (in_credit) begin
                credit_count++;
                prod_credits++;
                // A slot is freed only by a read that has already come out
                if (credit_count > out_count) begin
                    stop_with_error("an in_credit pulse came before its entry was read out");
                end
            end
            // Sleeping with entries still stored would lose them
            if (!pwr_awake) begin
                check_value("pending_entries_asleep", sb_q.size(), 0);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Command tasks
    // ------------------------------------------------------------------------

    task automatic push_entry(input logic sop, input logic eop, input logic [6:0] qid,
                              input logic [31:0] tag);
        queue_types_pkg::queue_entry_t e;
        logic [159:0]                  filler;
        int                            waited;
        filler    = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
        e.sop     = sop;
        e.eop     = eop;
        e.qid     = qid;
        e.payload = {filler[155:0], tag};
        waited    = 0;
        @(posedge wclk);
        #5;
        // A push needs a credit and an awake register file
        while (prod_credits == 0 || !pwr_awake) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error("a push never got a producer credit and an awake queue");
            end
            @(posedge wclk);
            #5;
        end
        in_push  = 1'b1;
        in_entry = e;
        sb_q.push_back(e);
        prod_credits--;
        @(posedge wclk);
        #5;
        in_push  = 1'b0;
    endtask

    task automatic grant_credits(input int k);
        int target;
        int waited;
        if (k > sb_q.size()) begin
            stop_with_error("a GRANT in the input file asks for more entries than are queued");
        end
        target = out_count + k;
        waited = 0;
        for (int i = 0; i < k; i++) begin
            @(posedge rclk);
            #5;
            out_credit = 1'b1;
            @(posedge rclk);
            #5;
            out_credit = 1'b0;
        end
        while (out_count < target) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error("granted entries did not come out of the queue");
            end
            @(posedge rclk);
        end
        // No further entry may follow the k granted ones
        repeat (10) @(posedge rclk);
        check_value("out_valid_count", out_count, target);
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        grant_credits(sb_q.size());
        while (prod_credits != DEPTH) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error("producer credits never returned to the full depth");
            end
            @(posedge wclk);
        end
        // A pending sleep request goes ahead once the queue is empty
        while (sleep_req && pwr_awake) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error("pwr_awake did not fall after the queue drained");
            end
            @(negedge wclk);
        end
    endtask

    task automatic request_sleep();
        @(posedge wclk);
        #5;
        sleep_req = 1'b1;
        if (sb_q.size() != 0) begin
            repeat (20) begin
                @(negedge wclk);
                check_value("pwr_awake", pwr_awake, 1);
            end
        end
    endtask

    task automatic request_wake();
        int waited;
        waited = 0;
        @(posedge wclk);
        #5;
        sleep_req = 1'b0;
        while (!pwr_awake) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error("pwr_awake did not rise after the wake request");
            end
            @(negedge wclk);
        end
    endtask

    task automatic watch_quiet(input int cycles);
        int start;
        start = out_count;
        repeat (cycles) @(posedge wclk);
        check_value("out_valid_count", out_count, start);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        int             fd;
        int             code;
        logic           done;
        logic [127:0]   cmd;
        logic [2047:0]  rest;
        logic [31:0]    a0;
        logic [31:0]    a1;
        logic [31:0]    a2;
        logic [31:0]    a3;
        void'($urandom(79420));
        arst_n        = 1'b0;
        scan_rstbypen = 1'b0;
        scan_byprst_b = 1'b1;
        in_push       = 1'b0;
        in_entry      = '0;
        out_credit    = 1'b0;
        sleep_req     = 1'b0;
        prod_credits  = DEPTH;
        out_count     = 0;
        credit_count  = 0;
        repeat (8) @(posedge wclk);
        #5;
        arst_n = 1'b1;

        // Idle queue after reset
        repeat (10) begin
            @(negedge wclk);
            check_value("out_valid", out_valid, 0);
            check_value("in_credit", in_credit, 0);
            check_value("pwr_awake", pwr_awake, 1);
        end

        fd = $fopen("bench/queue_input.txt", "r");
        if (fd == 0) begin
            stop_with_error("the input file bench/queue_input.txt could not be opened");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(rest, fd);
            end else if (cmd == "PUSH") begin
                code = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
                if (code != 4) begin
                    stop_with_error("a PUSH line in the input file lacks its four fields");
                end
                push_entry(a0[0], a1[0], a2[6:0], a3);
            end else if (cmd == "GRANT") begin
                code = $fscanf(fd, "%d", a0);
                grant_credits(a0);
            end else if (cmd == "QUIET") begin
                code = $fscanf(fd, "%d", a0);
                watch_quiet(a0);
            end else if (cmd == "SLEEP") begin
                request_sleep();
            end else if (cmd == "WAKE") begin
                request_wake();
            end else if (cmd == "DRAIN") begin
                drain_queue();
            end else begin
                stop_with_error($sformatf("unknown command %0s in the input file", cmd));
            end
        end
        $fclose(fd);

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* bench/queue_input.txt */
# Columns: command, then its fields; PUSH takes sop eop qid tag, all in hex
# GRANT takes a credit count and QUIET a cycle count, both decimal
PUSH 1 0 05 a0000001
PUSH 0 0 05 a0000002
PUSH 0 0 05 a0000003
PUSH 0 1 05 a0000004
PUSH 1 0 3c b0000001
PUSH 0 0 3c b0000002
PUSH 0 0 3c b0000003
PUSH 0 1 3c b0000004
QUIET 40
GRANT 3
GRANT 5
DRAIN
# Sleep with three entries still queued
PUSH 1 0 11 c0000001
PUSH 0 0 11 c0000002
PUSH 0 1 11 c0000003
SLEEP
GRANT 1
DRAIN
WAKE
# Traffic after the register file powered up again
PUSH 1 1 7f d0000001
PUSH 1 0 2a e0000001
PUSH 0 1 2a e0000002
DRAIN

/* files.f */
source/queue_types_pkg.sv
source/pwr_types_pkg.sv
source/reset_sync_scan.sv
source/rf_pg_dual_clk.sv
source/pwr_gate_seq.sv
source/queue_wr_ctrl.sv
source/queue_rd_ctrl.sv
source/dual_clk_queue.sv
bench/tb_dual_clk_queue.sv

/* run_sim.sh */
#!/bin/sh
# Builds the queue testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dual_clk_queue \
    -Mdir "$OBJ_DIR" \
    -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_dual_clk_queue" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
exit 1
